/* hdl/trng_pkg.sv */
package trng_pkg;

    // word assembly
    localparam int WORD_BITS = 32;
    localparam int BIT_CNT_W = $clog2(WORD_BITS);

    // repetition test run lengths, counted back from a word boundary
    localparam int WARN_RUN = 16;
    localparam int PERM_RUN = 32;

    // calibration window
    localparam int WINDOW_LEN = 1024;
    localparam int CNT_W      = 11;
    localparam logic [CNT_W-1:0] WIN_LAST = CNT_W'(WINDOW_LEN - 1);

    // lower bounds of the ones-count bands
    // good band is BAND_3 up to but not including BAND_4 (45..55 %)
    localparam logic [CNT_W-1:0] BAND_1 = 11'd128;
    localparam logic [CNT_W-1:0] BAND_2 = 11'd256;
    localparam logic [CNT_W-1:0] BAND_3 = 11'd461;
    localparam logic [CNT_W-1:0] BAND_4 = 11'd563;
    localparam logic [CNT_W-1:0] BAND_5 = 11'd768;
    localparam logic [CNT_W-1:0] BAND_6 = 11'd896;

    // trim code handling
    localparam logic [7:0] WARN_STEP = 8'd3;
    localparam logic [7:0] CAL_RESET = 8'hC0;

    // output queue
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

/* hdl/word_shifter.sv */
module word_shifter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sample,
    output logic [trng_pkg::WORD_BITS-1:0] word,
    output logic                          word_done
);

    logic [trng_pkg::BIT_CNT_W-1:0] bit_count;

    // newest raw bit enters at bit 0
    always_ff @(posedge clk) begin
        word <= {word[trng_pkg::WORD_BITS-2:0], sample};
    end

    // free running position inside the current word
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // last slot of the word
    assign word_done = &bit_count;

endmodule

/* hdl/run_monitor.sv */
module run_monitor (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [trng_pkg::WORD_BITS-1:0] word,
    input  logic                          word_done,
    input  logic                          cal_exhausted,
    output logic                          warn_ones,
    output logic                          warn_zeros,
    output logic                          perm_fail
);

    logic [trng_pkg::WARN_RUN-1:0] warn_bits;
    logic [trng_pkg::PERM_RUN-1:0] perm_bits;
    logic                          short_ones;
    logic                          short_zeros;
    logic                          long_run;

    // tail of the word that ends at the boundary
    assign warn_bits = word[trng_pkg::WARN_RUN-1:0];
    assign perm_bits = word[trng_pkg::PERM_RUN-1:0];

    assign short_ones  = &warn_bits;
    assign short_zeros = ~|warn_bits;

    // whole word stuck at one value
    assign long_run = (&perm_bits) || (~|perm_bits);

    // warnings only mean something on the boundary cycle
    assign warn_ones  = word_done && short_ones;
    assign warn_zeros = word_done && short_zeros;

    // a long run is only fatal once the source can no longer be trimmed
    always_ff @(posedge clk) begin
        if (rst) begin
            perm_fail <= 1'b0;
        end else if (word_done && long_run && cal_exhausted) begin
            perm_fail <= 1'b1;
        end
    end

    assert property (
        @(posedge clk) disable iff (rst)
        !(warn_ones && warn_zeros)
    );

endmodule

/* hdl/bias_calibrator.sv */
module bias_calibrator (
    input  logic       clk,
    input  logic       rst,
    input  logic       sample,
    input  logic       warn_ones,
    input  logic       warn_zeros,
    input  logic       debug_mode,
    input  logic [7:0] dbg_step,
    output logic [7:0] cal_n,
    output logic [7:0] cal_p,
    output logic       cal_exhausted,
    output logic       valid
);

    logic [trng_pkg::CNT_W-1:0] win_count;
    logic [trng_pkg::CNT_W-1:0] ones_count;
    logic [trng_pkg::CNT_W-1:0] ones_total;
    logic                       window_end;
    logic                       good;
    logic                       more_ones;
    logic [7:0]                 band_step;
    logic [7:0]                 step;
    logic [7:0]                 cal_n_next;
    logic [7:0]                 cal_p_next;

    function automatic logic [7:0] sat_add(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    function automatic logic [7:0] sat_sub(input logic [7:0] a, input logic [7:0] b);
        return (b > a) ? 8'h00 : a - b;
    endfunction

    // count including the sample of this cycle
    assign ones_total = ones_count + {{(trng_pkg::CNT_W - 1){1'b0}}, sample};
    assign window_end = (win_count == trng_pkg::WIN_LAST);

    // band classification of the finished window
    always_comb begin
        good      = 1'b0;
        more_ones = 1'b0;
        band_step = 8'd0;
        if (ones_total < trng_pkg::BAND_1) begin
            more_ones = 1'b1;
            band_step = 8'd3;
        end else if (ones_total < trng_pkg::BAND_2) begin
            more_ones = 1'b1;
            band_step = 8'd2;
        end else if (ones_total < trng_pkg::BAND_3) begin
            more_ones = 1'b1;
            band_step = 8'd1;
        end else if (ones_total < trng_pkg::BAND_4) begin
            good = 1'b1;
        end else if (ones_total < trng_pkg::BAND_5) begin
            band_step = 8'd1;
        end else if (ones_total < trng_pkg::BAND_6) begin
            band_step = 8'd2;
        end else begin
            band_step = 8'd3;
        end
    end

    // register interface takes over the step size in debug
    assign step = debug_mode ? dbg_step : band_step;

    // cal_p is the primary knob, cal_n takes over once cal_p is pinned
    always_comb begin
        cal_n_next = cal_n;
        cal_p_next = cal_p;
        if (window_end) begin
            if (!good) begin
                if (more_ones) begin
                    if (cal_p != 8'hFF) begin
                        cal_p_next = sat_add(cal_p, step);
                    end else begin
                        cal_n_next = sat_sub(cal_n, step);
                    end
                end else begin
                    if (cal_p != 8'h00) begin
                        cal_p_next = sat_sub(cal_p, step);
                    end else begin
                        cal_n_next = sat_add(cal_n, step);
                    end
                end
            end
        end else if (warn_ones) begin
            cal_p_next = sat_sub(cal_p, trng_pkg::WARN_STEP);
        end else if (warn_zeros) begin
            cal_n_next = sat_sub(cal_n, trng_pkg::WARN_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_count  <= '0;
            ones_count <= '0;
            cal_n      <= trng_pkg::CAL_RESET;
            cal_p      <= trng_pkg::CAL_RESET;
            valid      <= 1'b0;
        end else begin
            cal_n <= cal_n_next;
            cal_p <= cal_p_next;
            if (window_end) begin
                win_count  <= '0;
                ones_count <= '0;
                // once good, always good
                if (good) begin
                    valid <= 1'b1;
                end
            end else begin
                win_count  <= win_count + 1'b1;
                ones_count <= ones_total;
            end
        end
    end

    // either code at its floor means no trim range left
    assign cal_exhausted = (cal_n == 8'h00) || (cal_p == 8'h00);

endmodule

/* hdl/sample_fifo.sv */
module sample_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enq,
    input  logic                          deque,
    input  logic [trng_pkg::WORD_BITS-1:0] wdata,
    output logic [trng_pkg::WORD_BITS-1:0] rdata,
    output logic                          full,
    output logic                          empty
);

    logic [trng_pkg::WORD_BITS-1:0] mem [trng_pkg::FIFO_DEPTH];
    logic [trng_pkg::FIFO_AW-1:0]   wr_ptr;
    logic [trng_pkg::FIFO_AW-1:0]   rd_ptr;
    logic [trng_pkg::FIFO_AW:0]     count;
    logic                           do_read;

    // reads on an empty queue are dropped
    assign do_read = deque && !empty;

    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the level unchanged
            case ({enq, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head of queue, no read latency
    assign rdata = mem[rd_ptr];

    assign full  = (count == trng_pkg::FIFO_DEPTH);
    assign empty = (count == '0);

    assert property (
        @(posedge clk) disable iff (rst)
        !(enq && full)
    );

    assert property (
        @(posedge clk) disable iff (rst)
        count <= trng_pkg::FIFO_DEPTH
    );

endmodule

/* hdl/trng_health_top.sv */
module trng_health_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sample,
    input  logic                          deque,
    input  logic                          debug_mode,
    input  logic [7:0]                    dbg_step,
    output logic [trng_pkg::WORD_BITS-1:0] rdata,
    output logic                          empty,
    output logic                          full,
    output logic                          valid,
    output logic                          perm_fail,
    output logic [7:0]                    cal_n,
    output logic [7:0]                    cal_p
);

    logic [trng_pkg::WORD_BITS-1:0] word;
    logic                           word_done;
    logic                           warn_ones;
    logic                           warn_zeros;
    logic                           cal_exhausted;
    logic                           enq;

    word_shifter u_shifter (
        .clk       (clk),
        .rst       (rst),
        .sample    (sample),
        .word      (word),
        .word_done (word_done)
    );

    run_monitor u_monitor (
        .clk           (clk),
        .rst           (rst),
        .word          (word),
        .word_done     (word_done),
        .cal_exhausted (cal_exhausted),
        .warn_ones     (warn_ones),
        .warn_zeros    (warn_zeros),
        .perm_fail     (perm_fail)
    );

    bias_calibrator u_calibrator (
        .clk           (clk),
        .rst           (rst),
        .sample        (sample),
        .warn_ones     (warn_ones),
        .warn_zeros    (warn_zeros),
        .debug_mode    (debug_mode),
        .dbg_step      (dbg_step),
        .cal_n         (cal_n),
        .cal_p         (cal_p),
        .cal_exhausted (cal_exhausted),
        .valid         (valid)
    );

    // only clean words from a calibrated, healthy source; dropped when full
    assign enq = word_done && !warn_ones && !warn_zeros && !perm_fail && valid && !full;

    sample_fifo u_fifo (
        .clk   (clk),
        .rst   (rst),
        .enq   (enq),
        .deque (deque),
        .wdata (word),
        .rdata (rdata),
        .full  (full),
        .empty (empty)
    );

endmodule

/* tests/tb_trng_health.sv */
module tb_trng_health;

    localparam int CLK_HALF    = 4;
    localparam int WIN         = 1024;
    localparam int DEPTH       = 8;
    localparam int CAL_INIT    = 192;
    localparam int CYCLE_LIMIT = 14 * WIN + 1000;

    logic        clk;
    logic        rst;
    logic        sample;
    logic        deque;
    logic        debug_mode;
    logic [7:0]  dbg_step;
    logic [31:0] rdata;
    logic        empty;
    logic        full;
    logic        valid;
    logic        perm_fail;
    logic [7:0]  cal_n;
    logic [7:0]  cal_p;

    // reference model state, updated on each rising edge
    int          m_bit_cnt;
    int          m_win;
    int          m_ones;
    int          m_cal_n;
    int          m_cal_p;
    bit          m_valid;
    bit          m_perm;
    logic [31:0] m_sreg = '0;
    logic [31:0] m_q[$];

    bit checking = 1'b0;
    int n_checks = 0;
    int n_errors = 0;
    int n_pops   = 0;
    int n_warns  = 0;
    int n_cycles = 0;

    trng_health_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .deque      (deque),
        .debug_mode (debug_mode),
        .dbg_step   (dbg_step),
        .rdata      (rdata),
        .empty      (empty),
        .full       (full),
        .valid      (valid),
        .perm_fail  (perm_fail),
        .cal_n      (cal_n),
        .cal_p      (cal_p)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        n_cycles++;
        if (n_cycles >= CYCLE_LIMIT) begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // ones-count band of a window: positive asks for more ones, 0 is good
    function automatic int window_bias(input int ones);
        if (ones < 128) return 3;
        if (ones < 256) return 2;
        if (ones < 461) return 1;
        if (ones < 563) return 0;
        if (ones < 768) return -1;
        if (ones < 896) return -2;
        return -3;
    endfunction

    function automatic int trim_up(input int code, input int amt);
        return (code + amt > 255) ? 255 : code + amt;
    endfunction

    function automatic int trim_down(input int code, input int amt);
        return (code - amt < 0) ? 0 : code - amt;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("** Error %s: expected %h, got %h", name, exp, got);
            n_errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %-10s done at cycle %0d: %0d errors", name, n_cycles,
                 n_errors - errs_before);
    endtask

    always @(posedge clk) begin : model_step
        bit wd;
        bit wo;
        bit wz;
        bit run32;
        bit exh;
        bit enq_m;
        int total;
        int bias;
        int amt;
        wd    = (m_bit_cnt == 31);
        wo    = wd && (m_sreg[15:0] == 16'hFFFF);
        wz    = wd && (m_sreg[15:0] == 16'h0000);
        run32 = (m_sreg == 32'hFFFF_FFFF) || (m_sreg == 32'h0);
        exh   = (m_cal_n == 0) || (m_cal_p == 0);
        if (rst) begin
            m_bit_cnt = 0;
            m_win     = 0;
            m_ones    = 0;
            m_cal_n   = CAL_INIT;
            m_cal_p   = CAL_INIT;
            m_valid   = 1'b0;
            m_perm    = 1'b0;
            m_q.delete();
        end else begin
            // full is judged before this cycle's pop
            enq_m = wd && !wo && !wz && !m_perm && m_valid && (m_q.size() < DEPTH);
            if (deque && m_q.size() > 0) begin
                void'(m_q.pop_front());
            end
            if (enq_m) begin
                m_q.push_back(m_sreg);
            end
            total = m_ones + int'(sample);
            if (m_win == WIN - 1) begin
                // window end wins over a warning on the same cycle
                bias = window_bias(total);
                if (bias == 0) begin
                    m_valid = 1'b1;
                end else begin
                    amt = debug_mode ? int'(dbg_step) : ((bias > 0) ? bias : -bias);
                    if (bias > 0) begin
                        if (m_cal_p != 255) m_cal_p = trim_up(m_cal_p, amt);
                        else m_cal_n = trim_down(m_cal_n, amt);
                    end else begin
                        if (m_cal_p != 0) m_cal_p = trim_down(m_cal_p, amt);
                        else m_cal_n = trim_up(m_cal_n, amt);
                    end
                end
                m_win  = 0;
                m_ones = 0;
            end else begin
                m_win  = m_win + 1;
                m_ones = total;
                if (wo) begin
                    m_cal_p = trim_down(m_cal_p, 3);
                    n_warns++;
                end else if (wz) begin
                    m_cal_n = trim_down(m_cal_n, 3);
                    n_warns++;
                end
            end
            if (wd && run32 && exh) begin
                m_perm = 1'b1;
            end
            m_bit_cnt = (m_bit_cnt + 1) % 32;
        end
        m_sreg = {m_sreg[30:0], sample};
    end

    // outputs compared mid-cycle, after the edge has settled
    always @(negedge clk) begin
        if (checking) begin
            check_val("cal_n", 32'(cal_n), m_cal_n);
            check_val("cal_p", 32'(cal_p), m_cal_p);
            check_val("valid", 32'(valid), 32'(m_valid));
            check_val("perm_fail", 32'(perm_fail), 32'(m_perm));
            check_val("empty", 32'(empty), 32'(m_q.size() == 0));
            check_val("full", 32'(full), 32'(m_q.size() == DEPTH));
            if (deque && m_q.size() > 0) begin
                check_val("rdata", rdata, m_q[0]);
                n_pops++;
            end
        end
    end

    // inject 1: 16 ones at word end, 2: 16 zeros, 3: whole word stuck
    task automatic drive(input int cycles, input int ones_pct, input bit inject,
                         input int deque_pct);
        int kind;
        int bit_idx;
        logic run_val;
        kind    = 0;
        run_val = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            if (m_bit_cnt == 31) begin
                kind    = inject ? int'($urandom % 8) : 0;
                run_val = 1'($urandom);
            end
            // word bit that this sample lands in at the next boundary
            bit_idx = (m_bit_cnt == 31) ? 31 : 30 - m_bit_cnt;
            if (kind == 3) begin
                sample = run_val;
            end else if ((kind == 1 || kind == 2) && bit_idx < 16) begin
                sample = (kind == 1);
            end else begin
                sample = ($urandom % 100) < ones_pct;
            end
            deque = ($urandom % 100) < deque_pct;
        end
    endtask

    initial begin : main
        int errs;
        void'($urandom(32'h1691));
        rst        = 1'b1;
        sample     = 1'b0;
        deque      = 1'b0;
        debug_mode = 1'b0;
        dbg_step   = 8'h00;
        @(posedge clk);
        #1;
        checking = 1'b1;
        repeat (9) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = n_errors;
        check_val("cal_n", 32'(cal_n), CAL_INIT);
        check_val("cal_p", 32'(cal_p), CAL_INIT);
        check_val("empty", 32'(empty), 32'h1);
        check_val("valid", 32'(valid), 32'h0);
        check_val("full", 32'(full), 32'h0);
        check_val("perm_fail", 32'(perm_fail), 32'h0);
        end_test("reset", errs);

        errs = n_errors;
        drive(WIN, 10, 1'b0, 30);
        drive(WIN, 30, 1'b0, 30);
        drive(WIN, 50, 1'b0, 30);
        // consumer stalls for a window so the queue fills and drops words
        drive(WIN, 50, 1'b0, 0);
        assert (m_q.size() == DEPTH) else begin
            $display("queue did not fill while deque was held low");
            n_errors++;
        end
        drive(WIN, 70, 1'b0, 30);
        drive(WIN, 95, 1'b0, 30);
        assert (m_valid) else begin
            $display("no window of the bias sweep landed in the good band");
            n_errors++;
        end
        end_test("bias", errs);

        errs = n_errors;
        drive(2 * WIN, 50, 1'b1, 30);
        $display("run injection saw %0d warnings so far", n_warns);
        end_test("runs", errs);

        errs = n_errors;
        debug_mode = 1'b1;
        dbg_step   = 8'($urandom);
        drive(WIN, 20, 1'b0, 30);
        dbg_step = 8'($urandom);
        drive(WIN, 80, 1'b0, 30);
        debug_mode = 1'b0;
        end_test("debug", errs);

        // all ones until cal_p bottoms out and the next word fails
        errs = n_errors;
        drive(3 * WIN, 100, 1'b0, 30);
        assert (m_perm) else begin
            $display("perm_fail was not raised by the all-ones stretch");
            n_errors++;
        end
        end_test("exhaust", errs);

        errs = n_errors;
        drive(200, 50, 1'b0, 30);
        check_val("empty", 32'(empty), 32'h1);
        check_val("perm_fail", 32'(perm_fail), 32'h1);
        end_test("drain", errs);

        $display("checks %0d, words popped %0d, warnings %0d, errors %0d",
                 n_checks, n_pops, n_warns, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* trng_health.f */
hdl/trng_pkg.sv
hdl/word_shifter.sv
hdl/run_monitor.sv
hdl/bias_calibrator.sv
hdl/sample_fifo.sv
hdl/trng_health_top.sv
tests/tb_trng_health.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_trng_health
FILELIST = trng_health.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
